/* ps2_pkg.sv */
//------------------------------------------------
// PS/2 keyboard receiver shared definitions
// Scan-code and ASCII types, frame length and the
// special scan codes used by the key tracker
//------------------------------------------------

`default_nettype none

package ps2_pkg;

  //------------------------------------------------
  // Data types
  //------------------------------------------------

  typedef logic [7:0] scan_code_t;  // One set-2 scan code from the keyboard
  typedef logic [7:0] ascii_t;      // One translated ASCII character

  //------------------------------------------------
  // Serial frame
  //------------------------------------------------

  // Start bit, 8 data bits LSB first, odd parity, stop bit
  localparam int unsigned frame_bits = 11;

  //------------------------------------------------
  // Special scan codes
  //------------------------------------------------

  // Prefixes, held until the next real code arrives
  localparam scan_code_t extend_code  = 8'hE0;  // Extended key follows
  localparam scan_code_t release_code = 8'hF0;  // Key release follows

  // Modifier keys
  localparam scan_code_t left_shift_code  = 8'h12;
  localparam scan_code_t right_shift_code = 8'h59;
  localparam scan_code_t ctrl_code        = 8'h14;  // Left ctrl, right ctrl is E0 14
  localparam scan_code_t caps_lock_code   = 8'h58;  // Toggles on press only

endpackage

`default_nettype wire

/* ps2_frame_receiver.sv */
//------------------------------------------------
// PS/2 frame receiver
// Synchronizes the keyboard lines, shifts in one
// 11-bit frame per keyboard clock falling edge and
// drops stalled partial frames after a timeout
//------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

module ps2_frame_receiver #(
  parameter int unsigned watchdog_cycles = 2950  // Idle clk cycles before a partial frame is dropped
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ps2_clk,      // Keyboard clock, idles high
  input  logic                 ps2_data,     // Keyboard data, idles high
  output logic                 frame_valid,  // One-cycle pulse at end of frame
  output ps2_pkg::scan_code_t  frame_code    // Data bits of the frame
);

  import ps2_pkg::*;

  localparam int unsigned count_w = $clog2(frame_bits + 1);
  localparam int unsigned wd_w    = $clog2(watchdog_cycles + 1);

  logic                  clk_meta;     // First sync stage
  logic                  clk_sync;     // Second sync stage
  logic                  clk_prev;     // Delayed copy for edge detect
  logic                  data_meta;
  logic                  data_sync;
  logic                  fall_edge;    // Keyboard clock high to low
  logic                  any_edge;     // Either keyboard clock transition
  logic [count_w-1:0]    bit_count;    // Bits taken in the current frame
  logic [frame_bits-1:0] shift_q;      // Stop bit ends up on top
  logic [wd_w-1:0]       wd_count;     // Cycles since last keyboard clock edge
  logic                  wd_done;

  //------------------------------------------------
  // Input synchronizers
  //------------------------------------------------

  // Reset to the idle level so no false edge shows up after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      clk_prev  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end else begin
      clk_meta  <= ps2_clk;
      clk_sync  <= clk_meta;
      clk_prev  <= clk_sync;
      data_meta <= ps2_data;   // Same depth as the clock path
      data_sync <= data_meta;
    end
  end

  assign fall_edge = clk_prev & ~clk_sync;
  assign any_edge  = clk_prev ^ clk_sync;

  //------------------------------------------------
  // Bit counter and shift register
  //------------------------------------------------

  // Frame done once the 11th bit has been counted
  assign frame_valid = (bit_count == count_w'(frame_bits));

  always_ff @(posedge clk) begin
    if (reset || frame_valid) begin
      bit_count <= '0;                      // Restart for the next frame
    end else if (wd_done && clk_sync) begin
      bit_count <= '0;                      // Line idle too long, drop partial frame
    end else if (fall_edge) begin
      bit_count <= bit_count + 1'b1;
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (fall_edge) begin
      shift_q <= {data_sync, shift_q[frame_bits-1:1]};
    end
  end

  assign frame_code = shift_q[8:1];  // Skip start bit, drop parity and stop

  //------------------------------------------------
  // Inactivity watchdog
  //------------------------------------------------

  assign wd_done = (wd_count == wd_w'(watchdog_cycles));

  // Restarts on every keyboard clock edge, saturates when done
  always_ff @(posedge clk) begin
    if (reset || any_edge) begin
      wd_count <= '0;
    end else if (!wd_done) begin
      wd_count <= wd_count + 1'b1;
    end
  end

  //------------------------------------------------
  // Checks
  //------------------------------------------------

  // Counter restarts straight after a frame
  frame_valid_single: assert property (
    @(posedge clk) disable iff (reset) frame_valid |=> !frame_valid
  );

  // Frame never runs past its length
  bit_count_bound: assert property (
    @(posedge clk) disable iff (reset) bit_count <= count_w'(frame_bits)
  );

endmodule

`default_nettype wire

/* ps2_key_tracker.sv */
//------------------------------------------------
// PS/2 key tracker
// Holds extend and release prefixes, tracks shift,
// ctrl and caps lock, and decides which frames
// produce a key result
//------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

module ps2_key_tracker #(
  parameter bit trap_shift_keys = 1'b0  // 1 hides shift keys from the output
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 frame_valid,
  input  ps2_pkg::scan_code_t  frame_code,
  output logic                 key_strobe,     // Frame is a key for the output stage
  output logic                 hold_extended,  // E0 seen before this key
  output logic                 hold_released,  // F0 seen before this key
  output logic                 shift_on,
  output logic                 caps_lock,
  output logic                 ctrl_on
);

  import ps2_pkg::*;

  logic is_extend;
  logic is_release;
  logic is_prefix;
  logic is_shift;
  logic key_event;     // Any real key code, clears the prefix holds
  logic left_shift;
  logic right_shift;

  //------------------------------------------------
  // Code decode
  //------------------------------------------------

  assign is_extend  = (frame_code == extend_code);
  assign is_release = (frame_code == release_code);
  assign is_prefix  = is_extend | is_release;
  assign is_shift   = (frame_code == left_shift_code) | (frame_code == right_shift_code);

  assign key_event  = frame_valid & ~is_prefix;
  // Trapped shift keys still update state, they just give no result
  assign key_strobe = key_event & ~(trap_shift_keys & is_shift);

  //------------------------------------------------
  // Prefix holds
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset || key_event) begin
      hold_extended <= 1'b0;               // Used up by this key
      hold_released <= 1'b0;
    end else if (frame_valid) begin
      if (is_extend)  hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;  // E0 F0 keeps both
    end
  end

  //------------------------------------------------
  // Modifier state
  //------------------------------------------------

  // Press sets, press with release prefix clears
  always_ff @(posedge clk) begin
    if (reset) begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
      ctrl_on     <= 1'b0;
    end else if (frame_valid) begin
      if (frame_code == left_shift_code)  left_shift  <= ~hold_released;
      if (frame_code == right_shift_code) right_shift <= ~hold_released;
      if (frame_code == ctrl_code)        ctrl_on     <= ~hold_released;  // Left or right ctrl
    end
  end

  // Caps lock flips on each press, release is ignored
  always_ff @(posedge clk) begin
    if (reset) begin
      caps_lock <= 1'b0;
    end else if (frame_valid && frame_code == caps_lock_code && !hold_released) begin
      caps_lock <= ~caps_lock;
    end
  end

  assign shift_on = left_shift | right_shift;

  //------------------------------------------------
  // Checks
  //------------------------------------------------

  // Prefix bytes give no result and are held for the next key
  strobe_not_prefix: assert property (
    @(posedge clk) disable iff (reset)
      frame_valid && (frame_code == extend_code || frame_code == release_code)
        |-> !key_strobe ##1 (hold_extended || hold_released)
  );

endmodule

`default_nettype wire

/* ps2_ascii_map.sv */
//------------------------------------------------
// PS/2 scan code to ASCII map
// Reduced set-2 table: letters, digits, a few
// control keys and ctrl-C, everything else 00
//------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

module ps2_ascii_map (
  input  ps2_pkg::scan_code_t  frame_code,
  input  logic                 shift_on,   // State held before this frame
  input  logic                 caps_lock,
  input  logic                 ctrl_on,
  output ps2_pkg::ascii_t      ascii_code
);

  import ps2_pkg::*;

  logic upper;  // Letters go upper case

  assign upper = shift_on | caps_lock;

  // Table holds upper case, lower case is bit 5 set
  function automatic ascii_t letter(input ascii_t upper_ch, input logic up);
    letter = up ? upper_ch : (upper_ch | 8'h20);
  endfunction

  always_comb begin
    case (frame_code)
      //------------------------------------------------
      // Control keys, not affected by modifiers
      //------------------------------------------------
      8'h66: ascii_code = 8'h08;  // Backspace
      8'h0D: ascii_code = 8'h09;  // Tab
      8'h5A: ascii_code = 8'h0D;  // Enter
      8'h76: ascii_code = 8'h1B;  // Escape
      8'h29: ascii_code = 8'h20;  // Space
      8'h71: ascii_code = 8'h7F;  // Delete, also keypad DEL
      //------------------------------------------------
      // Digits, shift gives symbols on 1 to 5 only
      //------------------------------------------------
      8'h45: ascii_code = 8'h30;                       // 0
      8'h16: ascii_code = shift_on ? 8'h21 : 8'h31;    // 1 !
      8'h1E: ascii_code = shift_on ? 8'h40 : 8'h32;    // 2 @
      8'h26: ascii_code = shift_on ? 8'h23 : 8'h33;    // 3 #
      8'h25: ascii_code = shift_on ? 8'h24 : 8'h34;    // 4 $
      8'h2E: ascii_code = shift_on ? 8'h25 : 8'h35;    // 5 %
      8'h36: ascii_code = 8'h36;                       // 6
      8'h3D: ascii_code = 8'h37;                       // 7
      8'h3E: ascii_code = 8'h38;                       // 8
      8'h46: ascii_code = 8'h39;                       // 9
      //------------------------------------------------
      // Letters
      //------------------------------------------------
      8'h1C: ascii_code = letter(8'h41, upper);  // A
      8'h32: ascii_code = letter(8'h42, upper);  // B
      // Ctrl wins over case
      8'h21: ascii_code = ctrl_on ? 8'h03 : letter(8'h43, upper);
      8'h23: ascii_code = letter(8'h44, upper);  // D
      8'h24: ascii_code = letter(8'h45, upper);  // E
      8'h2B: ascii_code = letter(8'h46, upper);  // F
      8'h34: ascii_code = letter(8'h47, upper);  // G
      8'h33: ascii_code = letter(8'h48, upper);  // H
      8'h43: ascii_code = letter(8'h49, upper);  // I
      8'h3B: ascii_code = letter(8'h4A, upper);  // J
      8'h42: ascii_code = letter(8'h4B, upper);  // K
      8'h4B: ascii_code = letter(8'h4C, upper);  // L
      8'h3A: ascii_code = letter(8'h4D, upper);  // M
      8'h31: ascii_code = letter(8'h4E, upper);  // N
      8'h44: ascii_code = letter(8'h4F, upper);  // O
      8'h4D: ascii_code = letter(8'h50, upper);  // P
      8'h15: ascii_code = letter(8'h51, upper);  // Q
      8'h2D: ascii_code = letter(8'h52, upper);  // R
      8'h1B: ascii_code = letter(8'h53, upper);  // S
      8'h2C: ascii_code = letter(8'h54, upper);  // T
      8'h3C: ascii_code = letter(8'h55, upper);  // U
      8'h2A: ascii_code = letter(8'h56, upper);  // V
      8'h1D: ascii_code = letter(8'h57, upper);  // W
      8'h22: ascii_code = letter(8'h58, upper);  // X
      8'h35: ascii_code = letter(8'h59, upper);  // Y
      8'h1A: ascii_code = letter(8'h5A, upper);  // Z
      default: ascii_code = 8'h00;               // Not in the table
    endcase
  end

endmodule

`default_nettype wire

/* ps2_rx_output.sv */
//------------------------------------------------
// PS/2 receiver output stage
// Registers each key result and runs the
// data-ready / read handshake with the host
//------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

module ps2_rx_output (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 key_strobe,
  input  logic                 hold_extended,
  input  logic                 hold_released,
  input  ps2_pkg::scan_code_t  frame_code,
  input  ps2_pkg::ascii_t      ascii_code,
  input  logic                 read,          // Host has taken the result
  output ps2_pkg::scan_code_t  scan_code,
  output ps2_pkg::ascii_t      ascii,
  output logic                 key_extended,
  output logic                 key_released,
  output logic                 data_ready
);

  import ps2_pkg::*;

  typedef enum logic {
    st_empty,   // Waiting for a key
    st_ready    // Result held for the host
  } state_t;

  state_t state;

  // Result registers, a new key simply overwrites
  always_ff @(posedge clk) begin
    if (reset) begin
      scan_code    <= '0;
      ascii        <= '0;
      key_extended <= 1'b0;
      key_released <= 1'b0;
    end else if (key_strobe) begin
      scan_code    <= frame_code;
      ascii        <= ascii_code;
      key_extended <= hold_extended;
      key_released <= hold_released;
    end
  end

  // New key beats a read in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_empty;
    end else if (key_strobe) begin
      state <= st_ready;
    end else if (state == st_ready && read) begin
      state <= st_empty;
    end
  end

  assign data_ready = (state == st_ready);

  // Host handshake: only a read takes the result away
  ready_held_until_read: assert property (
    @(posedge clk) disable iff (reset) $fell(data_ready) |-> $past(read)
  );

endmodule

`default_nettype wire

/* ps2_keyboard_rx.sv */
//------------------------------------------------
// PS/2 keyboard receiver top level
// Frame receiver, key tracker, ASCII map and
// output stage with a ready / read handshake
//------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

module ps2_keyboard_rx #(
  parameter int unsigned watchdog_cycles = 2950,  // About 60 us at 49.152 MHz
  parameter bit          trap_shift_keys = 1'b0   // 1 hides shift keys from the output
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ps2_clk,
  input  logic                 ps2_data,
  input  logic                 read,
  output ps2_pkg::scan_code_t  scan_code,
  output ps2_pkg::ascii_t      ascii,
  output logic                 key_extended,
  output logic                 key_released,
  output logic                 shift_on,
  output logic                 caps_lock,
  output logic                 data_ready
);

  import ps2_pkg::*;

  logic       frame_valid;
  scan_code_t frame_code;
  logic       key_strobe;
  logic       hold_extended;
  logic       hold_released;
  logic       ctrl_on;
  ascii_t     ascii_code;

  // Serial line to scan code
  ps2_frame_receiver #(
    .watchdog_cycles (watchdog_cycles)
  ) u_frame_receiver (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .frame_valid (frame_valid),
    .frame_code  (frame_code)
  );

  // Prefixes and modifiers
  ps2_key_tracker #(
    .trap_shift_keys (trap_shift_keys)
  ) u_key_tracker (
    .clk           (clk),
    .reset         (reset),
    .frame_valid   (frame_valid),
    .frame_code    (frame_code),
    .key_strobe    (key_strobe),
    .hold_extended (hold_extended),
    .hold_released (hold_released),
    .shift_on      (shift_on),
    .caps_lock     (caps_lock),
    .ctrl_on       (ctrl_on)
  );

  // Uses modifier state from before this frame
  ps2_ascii_map u_ascii_map (
    .frame_code (frame_code),
    .shift_on   (shift_on),
    .caps_lock  (caps_lock),
    .ctrl_on    (ctrl_on),
    .ascii_code (ascii_code)
  );

  ps2_rx_output u_rx_output (
    .clk           (clk),
    .reset         (reset),
    .key_strobe    (key_strobe),
    .hold_extended (hold_extended),
    .hold_released (hold_released),
    .frame_code    (frame_code),
    .ascii_code    (ascii_code),
    .read          (read),
    .scan_code     (scan_code),
    .ascii         (ascii),
    .key_extended  (key_extended),
    .key_released  (key_released),
    .data_ready    (data_ready)
  );

endmodule

`default_nettype wire

/* tb_ps2_keyboard_rx.sv */
//------------------------------------------------
// PS/2 keyboard receiver testbench
// Directed tests driving serial frames into the DUT
// and checking each result through the handshake
//------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

module tb_ps2_keyboard_rx;

  import ps2_pkg::*;

  localparam int     clk_period = 40;    // ns
  localparam int     kbd_half   = 16;    // clk cycles per keyboard clock half-period
  localparam int     max_frames = 40;    // Upper bound on frames sent by all tests
  localparam longint timeout_ns = longint'(max_frames) * frame_bits * 2 * kbd_half * clk_period
                                  + 200_000;

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       read;
  scan_code_t scan_code;
  ascii_t     ascii;
  logic       key_extended;
  logic       key_released;
  logic       shift_on;
  logic       caps_lock;
  logic       data_ready;

  ps2_keyboard_rx #(
    .watchdog_cycles (64),
    .trap_shift_keys (1'b0)
  ) uut (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .read         (read),
    .scan_code    (scan_code),
    .ascii        (ascii),
    .key_extended (key_extended),
    .key_released (key_released),
    .shift_on     (shift_on),
    .caps_lock    (caps_lock),
    .data_ready   (data_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Run limit, sized for the longest expected test sequence
  initial begin
    #(timeout_ns);
    $display("Timeout at %0t: data_ready never arrived", $time);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  //------------------------------------------------
  // Compare tasks
  //------------------------------------------------

  task automatic report_failure();
    $display("Done: errors found");
    $fatal(1, "first error, run stopped");
  endtask

  task automatic check_scan(input string name, input scan_code_t exp, input scan_code_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_ascii(input string name, input ascii_t exp, input ascii_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      report_failure();
    end
  endtask

  //------------------------------------------------
  // Expected ASCII for the keys sent here
  //------------------------------------------------

  function automatic ascii_t ref_ascii(input scan_code_t code, input logic shift,
                                       input logic caps, input logic ctrl);
    case (code)
      8'h1C:   ref_ascii = (shift || caps) ? 8'h41 : 8'h61;  // A / a
      8'h21:   ref_ascii = ctrl ? 8'h03 : ((shift || caps) ? 8'h43 : 8'h63);  // C, ctrl-C
      8'h16:   ref_ascii = shift ? 8'h21 : 8'h31;  // 1 / !, caps ignored
      8'h71:   ref_ascii = 8'h7F;                  // Delete
      default: ref_ascii = 8'h00;                  // Modifiers and unknown keys
    endcase
  endfunction

  //------------------------------------------------
  // Keyboard side driver
  //------------------------------------------------

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Data set while keyboard clock is high, taken on its falling edge
  task automatic send_bit(input logic b);
    ps2_data = b;
    idle_cycles(kbd_half);
    ps2_clk = 1'b0;
    idle_cycles(kbd_half);
    ps2_clk = 1'b1;
  endtask

  // Start, data LSB first, odd parity, stop, cut short after nbits
  task automatic send_partial_frame(input scan_code_t code, input int nbits);
    logic [10:0] bits;
    bits = {1'b1, ~^code, code, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      send_bit(bits[i]);
    end
    ps2_data = 1'b1;  // Back to idle
  endtask

  task automatic send_frame(input scan_code_t code);
    send_partial_frame(code, frame_bits);
    idle_cycles(2 * kbd_half);  // Gap between frames
  endtask

  //------------------------------------------------
  // Host side
  //------------------------------------------------

  // Wait for a result, check it, hold for a while, then read it away
  task automatic take_key(input scan_code_t exp_scan, input ascii_t exp_ascii,
                          input logic exp_ext, input logic exp_rel, input int hold_cycles);
    while (data_ready !== 1'b1) @(negedge clk);  // Watchdog bounds this wait
    check_scan("scan_code", exp_scan, scan_code);
    check_ascii("ascii", exp_ascii, ascii);
    check_flag("key_extended", exp_ext, key_extended);
    check_flag("key_released", exp_rel, key_released);
    repeat (hold_cycles) begin
      @(negedge clk);
      check_flag("data_ready", 1'b1, data_ready);  // No read yet, must stay up
    end
    read = 1'b1;
    @(negedge clk);
    read = 1'b0;
    check_flag("data_ready", 1'b0, data_ready);
  endtask

  //------------------------------------------------
  // Tests
  //------------------------------------------------

  task automatic test_plain_key();
    send_frame(8'h1C);
    take_key(8'h1C, ref_ascii(8'h1C, 0, 0, 0), 1'b0, 1'b0, 10);
  endtask

  task automatic test_prefixes();
    send_frame(release_code);
    check_flag("data_ready", 1'b0, data_ready);  // Prefix alone gives nothing
    send_frame(8'h1C);
    take_key(8'h1C, ref_ascii(8'h1C, 0, 0, 0), 1'b0, 1'b1, 0);
    send_frame(extend_code);
    check_flag("data_ready", 1'b0, data_ready);
    send_frame(8'h71);
    take_key(8'h71, ref_ascii(8'h71, 0, 0, 0), 1'b1, 1'b0, 0);
  endtask

  task automatic test_shift();
    send_frame(left_shift_code);
    take_key(left_shift_code, ref_ascii(left_shift_code, 0, 0, 0), 1'b0, 1'b0, 0);
    check_flag("shift_on", 1'b1, shift_on);
    send_frame(8'h1C);
    take_key(8'h1C, ref_ascii(8'h1C, 1, 0, 0), 1'b0, 1'b0, 0);
    send_frame(8'h16);
    take_key(8'h16, ref_ascii(8'h16, 1, 0, 0), 1'b0, 1'b0, 0);
    send_frame(release_code);
    send_frame(left_shift_code);
    take_key(left_shift_code, ref_ascii(left_shift_code, 1, 0, 0), 1'b0, 1'b1, 0);
    check_flag("shift_on", 1'b0, shift_on);
  endtask

  task automatic test_caps_lock();
    send_frame(caps_lock_code);
    take_key(caps_lock_code, ref_ascii(caps_lock_code, 0, 0, 0), 1'b0, 1'b0, 0);
    check_flag("caps_lock", 1'b1, caps_lock);
    send_frame(8'h1C);
    take_key(8'h1C, ref_ascii(8'h1C, 0, 1, 0), 1'b0, 1'b0, 0);
    send_frame(8'h16);
    take_key(8'h16, ref_ascii(8'h16, 0, 1, 0), 1'b0, 1'b0, 0);  // Digits keep lower row
    send_frame(caps_lock_code);
    take_key(caps_lock_code, ref_ascii(caps_lock_code, 0, 1, 0), 1'b0, 1'b0, 0);
    check_flag("caps_lock", 1'b0, caps_lock);
  endtask

  task automatic test_ctrl_c();
    send_frame(ctrl_code);
    take_key(ctrl_code, ref_ascii(ctrl_code, 0, 0, 0), 1'b0, 1'b0, 0);
    send_frame(8'h21);
    take_key(8'h21, ref_ascii(8'h21, 0, 0, 1), 1'b0, 1'b0, 0);
    send_frame(release_code);  // Let go of ctrl again
    send_frame(ctrl_code);
    take_key(ctrl_code, ref_ascii(ctrl_code, 0, 0, 1), 1'b0, 1'b1, 0);
    send_frame(8'h21);
    take_key(8'h21, ref_ascii(8'h21, 0, 0, 0), 1'b0, 1'b0, 0);  // Plain c once ctrl is up
  endtask

  // Stalled frame must be dropped, next full frame decodes cleanly
  task automatic test_watchdog();
    send_partial_frame(8'h5A, 5);
    idle_cycles(64 + 2 + 50);
    check_flag("data_ready", 1'b0, data_ready);
    send_frame(8'h1C);
    take_key(8'h1C, ref_ascii(8'h1C, 0, 0, 0), 1'b0, 1'b0, 0);
    idle_cycles(4 * kbd_half);
    check_flag("data_ready", 1'b0, data_ready);  // Only one result
  endtask

  //------------------------------------------------
  // Main sequence
  //------------------------------------------------

  initial begin
    reset    = 1'b1;
    ps2_clk  = 1'b1;  // Lines idle high
    ps2_data = 1'b1;
    read     = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_flag("data_ready", 1'b0, data_ready);
    check_scan("scan_code", 8'h00, scan_code);
    check_ascii("ascii", 8'h00, ascii);
    check_flag("shift_on", 1'b0, shift_on);
    check_flag("caps_lock", 1'b0, caps_lock);

    test_plain_key();
    test_prefixes();
    test_shift();
    test_caps_lock();
    test_ctrl_c();
    test_watchdog();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* ps2_keyboard_rx.f */
ps2_pkg.sv
ps2_frame_receiver.sv
ps2_key_tracker.sv
ps2_ascii_map.sv
ps2_rx_output.sv
ps2_keyboard_rx.sv
tb_ps2_keyboard_rx.sv

/* Bender.yml */
package:
  name: ps2_keyboard_rx

sources:
  - ps2_pkg.sv
  - ps2_frame_receiver.sv
  - ps2_key_tracker.sv
  - ps2_ascii_map.sv
  - ps2_rx_output.sv
  - ps2_keyboard_rx.sv
  - target: test
    files:
      - tb_ps2_keyboard_rx.sv
